/* rtl/fetch_decode_top.sv */
`timescale 1ns/1ps

module fetch_decode_top
    import rv32i_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // Stall from later stages
    input  logic       pc_en,

    // Instruction memory
    output word_t      imem_addr,
    output logic [3:0] imem_rmask,
    input  word_t      imem_rdata,
    input  logic       imem_resp,

    // Decoded instruction
    output logic       dec_valid,
    output word_t      dec_pc,
    output order_t     dec_order,
    output word_t      dec_inst,
    output opcode_t    opcode,
    output reg_idx_t   rd,
    output reg_idx_t   rs1,
    output reg_idx_t   rs2,
    output logic [2:0] funct3,
    output logic [6:0] funct7,
    output word_t      imm
);

    if_id_if u_if_id ();

    fetch_stage u_fetch (
        .clk        (clk),
        .rst        (rst),
        .pc_en      (pc_en),
        .imem_resp  (imem_resp),
        .imem_rdata (imem_rdata),
        .imem_addr  (imem_addr),
        .imem_rmask (imem_rmask),
        .stage      (u_if_id)
    );

    inst_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .stage     (u_if_id),
        .dec_valid (dec_valid),
        .dec_pc    (dec_pc),
        .dec_order (dec_order),
        .dec_inst  (dec_inst),
        .opcode    (opcode),
        .rd        (rd),
        .rs1       (rs1),
        .rs2       (rs2),
        .funct3    (funct3),
        .funct7    (funct7),
        .imm       (imm)
    );

endmodule

/* rtl/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage
    import rv32i_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       pc_en,
    input  logic       imem_resp,
    input  word_t      imem_rdata,
    output word_t      imem_addr,
    output logic [3:0] imem_rmask,
    if_id_if.fetch     stage
);

    fetch_state_e state;
    fetch_state_e state_next;

    word_t  pc;
    word_t  pc_next;
    order_t order;
    logic   accept;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_RESET;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        imem_addr  = pc;
        imem_rmask = RMASK_IDLE;
        accept     = 1'b0;
        case (state)
            S_RESET: begin
                // One idle cycle before the first request
                state_next = S_FETCH;
            end
            S_FETCH: begin
                // Request stays up until a word is taken
                imem_rmask = RMASK_WORD;
                accept     = imem_resp && pc_en;
            end
            default: begin
                state_next = S_RESET;
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // PC and order
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // No redirects here
    assign pc_next = pc + PC_STEP;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc    <= RESET_PC;
            order <= '0;
        end else if (accept) begin
            pc    <= pc_next;
            order <= order + 64'd1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            stage.valid <= 1'b0;
        end else begin
            // A response seen while stalled is simply dropped
            stage.valid <= accept;
        end
    end

    // Word is tagged with the pc and order it was fetched under
    always_ff @(posedge clk) begin
        if (accept) begin
            stage.pc    <= pc;
            stage.order <= order;
            stage.inst  <= imem_rdata;
        end
    end

endmodule

/* rtl/if_id_if.sv */
`timescale 1ns/1ps

interface if_id_if
    import rv32i_pkg::*;
();

    // Stage register between fetch and decode
    word_t  pc;
    order_t order;
    word_t  inst;
    // One-cycle pulse per captured word
    logic   valid;

    modport fetch (
        output pc,
        output order,
        output inst,
        output valid
    );

    modport decode (
        input pc,
        input order,
        input inst,
        input valid
    );

endinterface

/* rtl/inst_decode.sv */
`timescale 1ns/1ps

module inst_decode
    import rv32i_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    if_id_if.decode    stage,
    output logic       dec_valid,
    output word_t      dec_pc,
    output order_t     dec_order,
    output word_t      dec_inst,
    output opcode_t    opcode,
    output reg_idx_t   rd,
    output reg_idx_t   rs1,
    output reg_idx_t   rs2,
    output logic [2:0] funct3,
    output logic [6:0] funct7,
    output word_t      imm
);

    word_t    inst;
    opcode_t  op;
    imm_fmt_e fmt;

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;
    word_t imm_next;

    assign inst = stage.inst;
    assign op   = inst[6:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Immediate format select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (op)
            OP_JALR,
            OP_LOAD,
            OP_IMM: begin
                fmt = IMM_I;
            end
            OP_STORE: begin
                fmt = IMM_S;
            end
            OP_BRANCH: begin
                fmt = IMM_B;
            end
            OP_LUI,
            OP_AUIPC: begin
                fmt = IMM_U;
            end
            OP_JAL: begin
                fmt = IMM_J;
            end
            default: begin
                // R-type and anything unknown
                fmt = IMM_NONE;
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Immediate assembly
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Sign bit is always inst[31]
    assign imm_i = {{21{inst[31]}}, inst[30:20]};
    assign imm_s = {{21{inst[31]}}, inst[30:25], inst[11:7]};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (fmt)
            IMM_I:   imm_next = imm_i;
            IMM_S:   imm_next = imm_s;
            IMM_B:   imm_next = imm_b;
            IMM_U:   imm_next = imm_u;
            IMM_J:   imm_next = imm_j;
            default: imm_next = '0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= stage.valid;
        end
    end

    // Fields hold their value between words
    always_ff @(posedge clk) begin
        if (stage.valid) begin
            dec_pc    <= stage.pc;
            dec_order <= stage.order;
            dec_inst  <= inst;
            opcode    <= op;
            rd        <= inst[11:7];
            rs1       <= inst[19:15];
            rs2       <= inst[24:20];
            funct3    <= inst[14:12];
            funct7    <= inst[31:25];
            imm       <= imm_next;
        end
    end

endmodule

/* rtl/rv32i_pkg.sv */
package rv32i_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Address, instruction and immediate
    typedef logic [31:0] word_t;

    // Retire order, wide enough to never wrap in practice
    typedef logic [63:0] order_t;

    typedef logic [4:0] reg_idx_t;

    typedef logic [6:0] opcode_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Fetch constants
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam word_t RESET_PC = 32'h6000_0000;

    // No compressed instructions, so every step is one word
    localparam word_t PC_STEP = 32'd4;

    // Byte lanes of a full word read
    localparam logic [3:0] RMASK_WORD = 4'b1111;
    localparam logic [3:0] RMASK_IDLE = 4'b0000;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Opcodes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Enums
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Immediate layout picked from the opcode
    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_NONE
    } imm_fmt_e;

    typedef enum logic {
        S_RESET,
        S_FETCH
    } fetch_state_e;

endpackage

/* sim.f */
rtl/rv32i_pkg.sv
rtl/if_id_if.sv
rtl/fetch_stage.sv
rtl/inst_decode.sv
rtl/fetch_decode_top.sv
tb/imem_model.sv
tb/tb_fetch_decode.sv

/* tb/imem_model.sv */
`timescale 1ns/1ps

module imem_model
    import rv32i_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  word_t      addr,
    input  logic [3:0] rmask,
    input  logic [1:0] delay,
    output word_t      rdata,
    output logic       resp
);

    localparam int DEPTH = 32;

    word_t       mem [DEPTH];
    bit          loaded [DEPTH];
    int unsigned wait_cnt;

    // Word k of the program sits at RESET_PC + 4k
    task automatic write_word(input int idx, input word_t w);
        mem[idx]    = w;
        loaded[idx] = 1'b1;
    endtask

    function automatic word_t read_word(input word_t a);
        word_t offset;
        offset = a - RESET_PC;
        if (offset[31:2] < DEPTH && loaded[offset[31:2]]) begin
            return mem[offset[31:2]];
        end
        // Unloaded locations return an address-derived pattern
        return a ^ 32'h5a3c_96e1;
    endfunction

    initial begin
        rdata    = '0;
        resp     = 1'b0;
        wait_cnt = 0;
    end

    always @(negedge clk) begin
        resp = 1'b0;
        if (rst) begin
            wait_cnt = 0;
        end else if (rmask == RMASK_WORD) begin
            if (wait_cnt == 0) begin
                // New request, latency of 1 to 3 cycles
                wait_cnt = delay;
            end else begin
                wait_cnt = wait_cnt - 1;
                if (wait_cnt == 0) begin
                    resp  = 1'b1;
                    rdata = read_word(addr);
                end
            end
        end else begin
            wait_cnt = 0;
        end
    end

endmodule

/* tb/tb_fetch_decode.sv */
`timescale 1ns/1ps

module tb_fetch_decode
    import rv32i_pkg::*;
();

    localparam int          NUM_TESTS      = 24;
    localparam int          RESET_CYCLES   = 8;
    localparam int          TIMEOUT_CYCLES = RESET_CYCLES + NUM_TESTS * 12;
    localparam logic [31:0] RAND_SEED      = 32'he4dd_e52f;

    logic       clk = 1'b0;
    logic       rst;
    logic       pc_en;
    word_t      imem_addr;
    logic [3:0] imem_rmask;
    word_t      imem_rdata;
    logic       imem_resp;
    logic [1:0] mem_delay;
    logic       dec_valid;
    word_t      dec_pc;
    order_t     dec_order;
    word_t      dec_inst;
    opcode_t    opcode;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm;

    word_t    prog_inst [NUM_TESTS];
    imm_fmt_e prog_fmt  [NUM_TESTS];

    int         error_count  = 0;
    int         pass_count   = 0;
    int         fail_count   = 0;
    int         cycle_count  = 0;
    int         stall_drops  = 0;
    logic       reset_done   = 1'b0;
    logic [1:0] accept_hist  = 2'b00;
    logic       drop_pending = 1'b0;
    word_t      drop_addr;

    initial begin
        forever #2 clk = ~clk;
    end

    fetch_decode_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .pc_en      (pc_en),
        .imem_addr  (imem_addr),
        .imem_rmask (imem_rmask),
        .imem_rdata (imem_rdata),
        .imem_resp  (imem_resp),
        .dec_valid  (dec_valid),
        .dec_pc     (dec_pc),
        .dec_order  (dec_order),
        .dec_inst   (dec_inst),
        .opcode     (opcode),
        .rd         (rd),
        .rs1        (rs1),
        .rs2        (rs2),
        .funct3     (funct3),
        .funct7     (funct7),
        .imm        (imm)
    );

    imem_model u_imem (
        .clk   (clk),
        .rst   (rst),
        .addr  (imem_addr),
        .rmask (imem_rmask),
        .delay (mem_delay),
        .rdata (imem_rdata),
        .resp  (imem_resp)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic word_t expected_imm(input word_t w, input imm_fmt_e f);
        logic signed [31:0] v;
        case (f)
            IMM_I:   v = $signed(w[31:20]);
            IMM_S:   v = $signed({w[31:25], w[11:7]});
            IMM_B:   v = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0});
            IMM_U:   v = {w[31:12], 12'h000};
            IMM_J:   v = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0});
            default: v = '0;
        endcase
        return v;
    endfunction

    task automatic add_entry(input int k, input word_t w, input imm_fmt_e f);
        prog_inst[k] = w;
        prog_fmt[k]  = f;
        u_imem.write_word(k, w);
    endtask

    task automatic load_program();
        add_entry(0,  32'h0010_0093, IMM_I);
        add_entry(1,  32'hfff0_8113, IMM_I);
        add_entry(2,  32'h1234_52b7, IMM_U);
        add_entry(3,  32'hfedc_b537, IMM_U);
        add_entry(4,  32'h8000_0197, IMM_U);
        add_entry(5,  32'h0000_1217, IMM_U);
        add_entry(6,  32'h0080_00ef, IMM_J);
        add_entry(7,  32'hffdf_f06f, IMM_J);
        add_entry(8,  32'h7ff0_016f, IMM_J);
        add_entry(9,  32'h0002_80e7, IMM_I);
        add_entry(10, 32'h8000_8067, IMM_I);
        add_entry(11, 32'h0020_8863, IMM_B);
        add_entry(12, 32'hfe41_9ce3, IMM_B);
        add_entry(13, 32'h7e20_cfe3, IMM_B);
        add_entry(14, 32'h0041_2303, IMM_I);
        add_entry(15, 32'hfff4_0383, IMM_I);
        add_entry(16, 32'h0051_2423, IMM_S);
        add_entry(17, 32'hfe61_2e23, IMM_S);
        add_entry(18, 32'h80a5_8fa3, IMM_S);
        add_entry(19, 32'h0020_81b3, IMM_NONE);
        add_entry(20, 32'h4011_8233, IMM_NONE);
        add_entry(21, 32'h0020_f2b3, IMM_NONE);
        add_entry(22, 32'hfff4_c493, IMM_I);
        add_entry(23, 32'h4035_5513, IMM_I);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reporting
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("[ERROR] t=%0t %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
        error_count++;
    endtask

    task automatic close_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            pass_count++;
            $display("PASS  %s", name);
        end else begin
            fail_count++;
            $display("FAIL  %s (%0d errors)", name, error_count - errors_before);
        end
    endtask

    // Called on a falling edge while dec_valid is high
    task automatic check_entry(input int k);
        word_t  w;
        word_t  exp_pc;
        order_t exp_order;
        word_t  exp_imm;
        int     errors_before;
        w             = prog_inst[k];
        exp_pc        = RESET_PC + (k << 2);
        exp_order     = k;
        exp_imm       = expected_imm(w, prog_fmt[k]);
        errors_before = error_count;
        if (dec_pc !== exp_pc) report_mismatch("dec_pc", exp_pc, dec_pc);
        if (dec_order !== exp_order) report_mismatch("dec_order", exp_order, dec_order);
        if (dec_inst !== w) report_mismatch("dec_inst", w, dec_inst);
        if (opcode !== w[6:0]) report_mismatch("opcode", w[6:0], opcode);
        if (rd !== w[11:7]) report_mismatch("rd", w[11:7], rd);
        if (rs1 !== w[19:15]) report_mismatch("rs1", w[19:15], rs1);
        if (rs2 !== w[24:20]) report_mismatch("rs2", w[24:20], rs2);
        if (funct3 !== w[14:12]) report_mismatch("funct3", w[14:12], funct3);
        if (funct7 !== w[31:25]) report_mismatch("funct7", w[31:25], funct7);
        if (imm !== exp_imm) report_mismatch("imm", exp_imm, imm);
        close_test($sformatf("entry %0d inst 0x%08h", k, w), errors_before);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Monitors
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, decoded words stopped arriving", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    // dec_valid follows an accepting edge by exactly two edges
    always @(posedge clk) begin
        if (rst) begin
            accept_hist  = 2'b00;
            drop_pending = 1'b0;
        end else begin
            if (dec_valid !== accept_hist[1]) begin
                report_mismatch("dec_valid", accept_hist[1], dec_valid);
            end
            if (drop_pending && imem_addr !== drop_addr) begin
                report_mismatch("imem_addr", drop_addr, imem_addr);
            end
            drop_pending = 1'b0;
            if (imem_resp && !pc_en && imem_rmask == RMASK_WORD) begin
                // Dropped word, same address must come back
                stall_drops++;
                drop_pending = 1'b1;
                drop_addr    = imem_addr;
            end
            accept_hist = {accept_hist[0], imem_resp && pc_en && imem_rmask == RMASK_WORD};
        end
    end

    // Random stall pattern and memory latency
    initial begin
        mem_delay = ($urandom(RAND_SEED) % 3) + 1;
        wait (reset_done);
        forever begin
            @(negedge clk);
            pc_en = ($urandom % 3) != 0;
            @(posedge clk);
            // Taken by the memory when its next request starts
            mem_delay = ($urandom % 3) + 1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int k;
        int errors_before;
        rst   = 1'b1;
        pc_en = 1'b0;
        load_program();

        errors_before = error_count;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            if (dec_valid !== 1'b0) report_mismatch("dec_valid", 1'b0, dec_valid);
            if (imem_rmask !== RMASK_IDLE) report_mismatch("imem_rmask", RMASK_IDLE, imem_rmask);
        end
        rst        = 1'b0;
        reset_done = 1'b1;
        @(negedge clk);
        if (imem_rmask !== RMASK_WORD) report_mismatch("imem_rmask", RMASK_WORD, imem_rmask);
        if (imem_addr !== RESET_PC) report_mismatch("imem_addr", RESET_PC, imem_addr);
        close_test("reset and first request", errors_before);

        for (k = 0; k < NUM_TESTS; k++) begin
            @(negedge clk);
            while (dec_valid !== 1'b1) begin
                @(negedge clk);
            end
            check_entry(k);
        end

        errors_before = error_count;
        if (stall_drops == 0) begin
            $display("No response arrived while pc_en was low, stall path was never exercised");
            error_count++;
        end
        close_test($sformatf("stall retry, %0d dropped responses", stall_drops), errors_before);

        $display("Summary: %0d passed, %0d failed, %0d errors", pass_count, fail_count,
                 error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
